/* logic/bsBertPkg.sv */
`default_nettype none

package bsBertPkg;

    // **************************************************************************
    // Widths
    // **************************************************************************
    localparam int SampleWidth = 18;
    localparam int DacWidth = 14;
    localparam int AddrWidth = 13;
    localparam int RegWidth = 32;
    localparam int BusWidth = 16;
    localparam int ByteCount = RegWidth / 8;

    // Select field widths inside the control registers
    localparam int DacSelWidth = 3;
    localparam int RouteSelWidth = 4;

    // **************************************************************************
    // Byte address map
    // **************************************************************************
    localparam logic [AddrWidth-1:0] VersionAddr = AddrWidth'('h000);
    localparam logic [AddrWidth-1:0] DacSelectAddr = AddrWidth'('h004);
    localparam logic [AddrWidth-1:0] RouteSelectAddr = AddrWidth'('h008);

    // Lane i sits at LaneReadBase + 4*i
    localparam logic [AddrWidth-1:0] LaneReadBase = AddrWidth'('h010);

    // **************************************************************************
    // Select codes
    // **************************************************************************
    // Any other DAC source code falls back to channel 0
    localparam logic [DacSelWidth-1:0] SelCh0 = 3'd0;
    localparam logic [DacSelWidth-1:0] SelCh1 = 3'd1;

    // Unused router codes drive low
    localparam logic [RouteSelWidth-1:0] RouteCh0 = 4'd0;
    localparam logic [RouteSelWidth-1:0] RouteCh1 = 4'd2;
    localparam logic [RouteSelWidth-1:0] RouteCh0Alt = 4'd4;

    // Counts and reset values
    localparam int NumRouters = 5;
    localparam logic [DacWidth-1:0] DacMidscale = 14'h2000;

    // **************************************************************************
    // Types
    // **************************************************************************
    typedef logic signed [SampleWidth-1:0] sample_t;
    typedef logic [DacWidth-1:0] dacWord_t;

    // One recovered channel from a bit synchronizer
    typedef struct packed {
        logic    sampleEn;
        sample_t sample;
        logic    symClk;
        logic    symBit;
        logic    lock;
    } channel_t;

    // Processor write side
    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [RegWidth-1:0]  data;
        logic [ByteCount-1:0] byteWr;
    } busWrite_t;

    typedef logic [NumRouters-1:0][RouteSelWidth-1:0] routeSelect_t;

endpackage

`default_nettype wire

/* logic/busRegs.sv */
`default_nettype none

module busRegs #(
    parameter int NumDacs = 3,
    parameter logic [bsBertPkg::RegWidth-1:0] VersionNumber = 415
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          cs,
    input  bsBertPkg::busWrite_t                          busIn,
    output logic [NumDacs-1:0][bsBertPkg::DacSelWidth-1:0] dacSelect,
    output bsBertPkg::routeSelect_t                       routeSelect,
    output logic [bsBertPkg::RegWidth-1:0]                regReadData
);

    localparam int AW = bsBertPkg::AddrWidth;
    localparam int DSW = bsBertPkg::DacSelWidth;
    localparam int RSW = bsBertPkg::RouteSelWidth;

    // Registers are decoded on the 32-bit word address
    logic [AW-3:0] wordAddr;
    logic dacSelHit;
    logic routeSelHit;
    logic [bsBertPkg::RegWidth-1:0] dacSelWord;
    logic [bsBertPkg::RegWidth-1:0] routeSelWord;

    assign wordAddr = busIn.addr[AW-1:2];
    assign dacSelHit = cs && (wordAddr == bsBertPkg::DacSelectAddr[AW-1:2]);
    assign routeSelHit = cs && (wordAddr == bsBertPkg::RouteSelectAddr[AW-1:2]);

    // **************************************************************************
    // Byte-strobed writes
    // **************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            dacSelect <= '0;
            routeSelect <= '0;
        end else begin
            // One lane select per byte
            for (int i = 0; i < NumDacs; i++) begin
                if (dacSelHit && busIn.byteWr[i]) begin
                    dacSelect[i] <= busIn.data[8*i +: DSW];
                end
            end
            // Two router nibbles share a byte
            for (int j = 0; j < bsBertPkg::NumRouters; j++) begin
                if (routeSelHit && busIn.byteWr[(RSW*j)/8]) begin
                    routeSelect[j] <= busIn.data[RSW*j +: RSW];
                end
            end
        end
    end

    // **************************************************************************
    // Register readback
    // **************************************************************************
    always_comb begin
        dacSelWord = '0;
        for (int i = 0; i < NumDacs; i++) begin
            dacSelWord[8*i +: DSW] = dacSelect[i];
        end
    end

    always_comb begin
        routeSelWord = '0;
        for (int j = 0; j < bsBertPkg::NumRouters; j++) begin
            routeSelWord[RSW*j +: RSW] = routeSelect[j];
        end
    end

    always_comb begin
        case (wordAddr)
            bsBertPkg::VersionAddr[AW-1:2]: begin
                regReadData = VersionNumber;
            end
            bsBertPkg::DacSelectAddr[AW-1:2]: begin
                regReadData = dacSelWord;
            end
            bsBertPkg::RouteSelectAddr[AW-1:2]: begin
                regReadData = routeSelWord;
            end
            default: begin
                regReadData = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/dacLane.sv */
`default_nettype none

module dacLane (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [bsBertPkg::DacSelWidth-1:0]  select,
    input  bsBertPkg::channel_t                ch0,
    input  bsBertPkg::channel_t                ch1,
    output bsBertPkg::sample_t                 heldSample,
    output bsBertPkg::dacWord_t                dacWord
);

    localparam int SW = bsBertPkg::SampleWidth;
    localparam int DW = bsBertPkg::DacWidth;

    bsBertPkg::sample_t srcSample;
    logic srcEn;
    bsBertPkg::sample_t pickSample;
    logic pickEn;

    // Unknown source codes behave as channel 0
    always_comb begin
        case (select)
            bsBertPkg::SelCh0: begin
                srcSample = ch0.sample;
                srcEn = ch0.sampleEn;
            end
            bsBertPkg::SelCh1: begin
                srcSample = ch1.sample;
                srcEn = ch1.sampleEn;
            end
            default: begin
                srcSample = ch0.sample;
                srcEn = ch0.sampleEn;
            end
        endcase
    end

    // Stage 1 register the chosen channel
    always_ff @(posedge clk) begin
        pickSample <= srcSample;
        if (reset) begin
            pickEn <= 1'b0;
        end else begin
            pickEn <= srcEn;
        end
    end

    // Stage 2 holds the latest sample in place of the interpolator
    // Stage 3 keeps the top bits and flips the sign for offset binary
    always_ff @(posedge clk) begin
        if (reset) begin
            heldSample <= '0;
            dacWord <= bsBertPkg::DacMidscale;
        end else begin
            if (pickEn) begin
                heldSample <= pickSample;
            end
            dacWord <= {~heldSample[SW-1], heldSample[SW-2 -: DW-1]};
        end
    end

endmodule

`default_nettype wire

/* logic/readbackMux.sv */
`default_nettype none

module readbackMux #(
    parameter int NumDacs = 3
) (
    input  logic                                  cs,
    input  logic                                  rd,
    input  logic [bsBertPkg::AddrWidth-1:0]       addr,
    input  logic [bsBertPkg::RegWidth-1:0]        regReadData,
    input  bsBertPkg::sample_t [NumDacs-1:0]      heldSamples,
    output logic [bsBertPkg::BusWidth-1:0]        readData,
    output logic                                  readDataEn
);

    localparam int AW = bsBertPkg::AddrWidth;
    localparam int RW = bsBertPkg::RegWidth;
    localparam int SW = bsBertPkg::SampleWidth;
    localparam int BW = bsBertPkg::BusWidth;

    logic [RW-1:0] readWord;

    // **************************************************************************
    // Register space or lane readback
    // **************************************************************************
    always_comb begin
        logic [AW-1:0] laneAddr;
        readWord = regReadData;
        for (int i = 0; i < NumDacs; i++) begin
            laneAddr = bsBertPkg::LaneReadBase + AW'(4 * i);
            if (addr[AW-1:2] == laneAddr[AW-1:2]) begin
                // Held sample sign-extended to the full register
                readWord = {{(RW-SW){heldSamples[i][SW-1]}}, heldSamples[i]};
            end
        end
    end

    // **************************************************************************
    // Half-word select and read enable
    // **************************************************************************
    assign readDataEn = cs & rd;

    always_comb begin
        if (!readDataEn) begin
            readData = '0;
        end else if (addr[1]) begin
            readData = readWord[RW-1 -: BW];
        end else begin
            readData = readWord[BW-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/outputRouter.sv */
`default_nettype none

module outputRouter (
    input  bsBertPkg::routeSelect_t                routeSelect,
    input  bsBertPkg::channel_t                    ch0,
    input  bsBertPkg::channel_t                    ch1,
    output logic [bsBertPkg::NumRouters-1:0]       routeClk,
    output logic [bsBertPkg::NumRouters-1:0]       routeData,
    output logic                                   ch0Lockn,
    output logic                                   ch1Lockn
);

    // **************************************************************************
    // Clock and data routers
    // **************************************************************************
    // Router order
    //   0 bitsync coax, 1 bitsync RS422, 2 encoder coax,
    //   3 framesync, 4 framesync RS422
    always_comb begin
        for (int j = 0; j < bsBertPkg::NumRouters; j++) begin
            case (routeSelect[j])
                bsBertPkg::RouteCh0,
                bsBertPkg::RouteCh0Alt: begin
                    routeClk[j] = ch0.symClk;
                    routeData[j] = ch0.symBit;
                end
                bsBertPkg::RouteCh1: begin
                    routeClk[j] = ch1.symClk;
                    routeData[j] = ch1.symBit;
                end
                default: begin
                    // Decoder, BERT and PN sources are not fitted
                    routeClk[j] = 1'b0;
                    routeData[j] = 1'b0;
                end
            endcase
        end
    end

    // **************************************************************************
    // Lock indicators
    // **************************************************************************
    // LEDs are active low
    assign ch0Lockn = ~ch0.lock;
    assign ch1Lockn = ~ch1.lock;

endmodule

`default_nettype wire

/* logic/bsBertTop.sv */
`default_nettype none

module bsBertTop #(
    parameter int NumDacs = 3,
    parameter logic [bsBertPkg::RegWidth-1:0] VersionNumber = 415
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  bsBertPkg::channel_t                    ch0,
    input  bsBertPkg::channel_t                    ch1,
    input  bsBertPkg::busWrite_t                   busIn,
    input  logic                                   cs,
    input  logic                                   rd,
    output bsBertPkg::dacWord_t [NumDacs-1:0]      dacData,
    output logic                                   dacClk,
    output logic                                   bsClk,
    output logic                                   bsData,
    output logic                                   bsDiffClk,
    output logic                                   bsDiffData,
    output logic                                   encClk,
    output logic                                   encData,
    output logic                                   fsClk,
    output logic                                   fsData,
    output logic                                   fsDiffClk,
    output logic                                   fsDiffData,
    output logic                                   ch0Lockn,
    output logic                                   ch1Lockn,
    output logic [bsBertPkg::BusWidth-1:0]         readData,
    output logic                                   readDataEn
);

    logic [NumDacs-1:0][bsBertPkg::DacSelWidth-1:0] dacSelect;
    bsBertPkg::routeSelect_t routeSelect;
    logic [bsBertPkg::RegWidth-1:0] regReadData;
    bsBertPkg::sample_t [NumDacs-1:0] heldSamples;
    logic [bsBertPkg::NumRouters-1:0] routeClk;
    logic [bsBertPkg::NumRouters-1:0] routeData;

    // **************************************************************************
    // Control registers
    // **************************************************************************
    busRegs #(
        .NumDacs(NumDacs),
        .VersionNumber(VersionNumber)
    ) regs (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .busIn(busIn),
        .dacSelect(dacSelect),
        .routeSelect(routeSelect),
        .regReadData(regReadData)
    );

    // **************************************************************************
    // DAC lanes
    // **************************************************************************
    for (genvar i = 0; i < NumDacs; i++) begin : gLane
        dacLane lane (
            .clk(clk),
            .reset(reset),
            .select(dacSelect[i]),
            .ch0(ch0),
            .ch1(ch1),
            .heldSample(heldSamples[i]),
            .dacWord(dacData[i])
        );
    end

    // DACs run straight off the system clock
    assign dacClk = clk;

    // **************************************************************************
    // Clock and data outputs
    // **************************************************************************
    outputRouter router (
        .routeSelect(routeSelect),
        .ch0(ch0),
        .ch1(ch1),
        .routeClk(routeClk),
        .routeData(routeData),
        .ch0Lockn(ch0Lockn),
        .ch1Lockn(ch1Lockn)
    );

    assign bsClk = routeClk[0];
    assign bsData = routeData[0];
    assign bsDiffClk = routeClk[1];
    assign bsDiffData = routeData[1];
    assign encClk = routeClk[2];
    assign encData = routeData[2];
    assign fsClk = routeClk[3];
    assign fsData = routeData[3];
    assign fsDiffClk = routeClk[4];
    assign fsDiffData = routeData[4];

    // **************************************************************************
    // Processor read data
    // **************************************************************************
    readbackMux #(
        .NumDacs(NumDacs)
    ) readMux (
        .cs(cs),
        .rd(rd),
        .addr(busIn.addr),
        .regReadData(regReadData),
        .heldSamples(heldSamples),
        .readData(readData),
        .readDataEn(readDataEn)
    );

endmodule

`default_nettype wire

/* tests/tbClock.sv */
`default_nettype none

module tbClock #(
    parameter int Period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(Period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tests/bsBertTb.sv */
`default_nettype none

module bsBertTb;

    localparam int NumDacs = 3;
    localparam int Version = 415;
    localparam int Timeout = 10;

    logic clk;
    logic reset;
    bsBertPkg::channel_t ch0;
    bsBertPkg::channel_t ch1;
    bsBertPkg::busWrite_t busIn;
    logic cs;
    logic rd;
    bsBertPkg::dacWord_t [NumDacs-1:0] dacData;
    logic dacClk;
    logic bsClk, bsDiffClk, encClk, fsClk, fsDiffClk;
    logic bsData, bsDiffData, encData, fsData, fsDiffData;
    logic ch0Lockn;
    logic ch1Lockn;
    logic [15:0] readData;
    logic readDataEn;

    // Router outputs in router order
    wire [4:0] outClk = {fsDiffClk, fsClk, encClk, bsDiffClk, bsClk};
    wire [4:0] outData = {fsDiffData, fsData, encData, bsDiffData, bsData};

    // Shadow select registers and the expected DAC words
    logic [31:0] dacSelWord;
    logic [31:0] routeSelWord;
    logic [NumDacs-1:0] laneEn;
    bsBertPkg::sample_t laneSample [NumDacs];
    logic [1:0] enPipe [NumDacs];
    bsBertPkg::sample_t [1:0] samplePipe [NumDacs];
    bsBertPkg::dacWord_t dacExpect [NumDacs];
    integer seed;

    tbClock #(.Period(4)) clockGen (.clk(clk));

    bsBertTop #(.NumDacs(NumDacs), .VersionNumber(Version)) DUT (.*);

    function automatic void stopOnFailure();
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failed check");
    endfunction

    function automatic void reportMismatch(input string name, input logic [31:0] got,
                                           input logic [31:0] expected);
        $display("[ERROR] %s got 0x%h expected 0x%h", name, got, expected);
        stopOnFailure();
    endfunction

    // Offset binary from the top 14 bits with the sign bit flipped
    function automatic bsBertPkg::dacWord_t dacFromSample(input bsBertPkg::sample_t s);
        bsBertPkg::dacWord_t w;
        w = s[17:4];
        w[13] = !w[13];
        return w;
    endfunction

    function automatic logic [1:0] routeExpect(input logic [3:0] code, input logic [1:0] src0,
                                               input logic [1:0] src1);
        if (code == bsBertPkg::RouteCh0 || code == bsBertPkg::RouteCh0Alt) begin
            return src0;
        end else if (code == bsBertPkg::RouteCh1) begin
            return src1;
        end
        return 2'b00;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strobes, input logic [31:0] mask);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (strobes[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged & mask;
    endfunction

    // Only code 1 picks channel 1
    always_comb begin
        for (int i = 0; i < NumDacs; i++) begin
            if (dacSelWord[8*i +: 3] == 3'd1) begin
                laneEn[i] = ch1.sampleEn;
                laneSample[i] = ch1.sample;
            end else begin
                laneEn[i] = ch0.sampleEn;
                laneSample[i] = ch0.sample;
            end
        end
    end

    // Enable to DAC pin is three edges
    always @(posedge clk) begin
        for (int i = 0; i < NumDacs; i++) begin
            if (reset) begin
                enPipe[i] <= '0;
                samplePipe[i] <= '0;
                dacExpect[i] <= bsBertPkg::DacMidscale;
            end else begin
                enPipe[i] <= {enPipe[i][0], laneEn[i]};
                samplePipe[i] <= {samplePipe[i][0], laneSample[i]};
                if (enPipe[i][1]) begin
                    dacExpect[i] <= dacFromSample(samplePipe[i][1]);
                end
            end
        end
    end

    // **************************************************************************
    // Assertions
    // **************************************************************************
    assert property (@(posedge clk) ch0Lockn == !ch0.lock)
        else reportMismatch("ch0Lockn", 32'($sampled(ch0Lockn)), 32'(!$sampled(ch0.lock)));
    assert property (@(posedge clk) ch1Lockn == !ch1.lock)
        else reportMismatch("ch1Lockn", 32'($sampled(ch1Lockn)), 32'(!$sampled(ch1.lock)));
    assert property (@(posedge clk) readDataEn == (cs && rd))
        else reportMismatch("readDataEn", 32'($sampled(readDataEn)), 32'($sampled(cs && rd)));
    assert property (@(posedge clk) !readDataEn |-> readData == 16'h0000)
        else reportMismatch("readData", 32'($sampled(readData)), 32'h0);

    // DAC clock follows clk in both phases
    always @(clk) begin
        #1;
        assert (dacClk === clk)
            else reportMismatch("dacClk", 32'(dacClk), 32'(clk));
    end

    for (genvar j = 0; j < 5; j++) begin : gRouteCheck
        assert property (@(posedge clk) disable iff (reset)
            {outClk[j], outData[j]} == routeExpect(routeSelWord[4*j +: 4],
                {ch0.symClk, ch0.symBit}, {ch1.symClk, ch1.symBit}))
            else reportMismatch($sformatf("router %0d clk,data", j),
                32'($sampled({outClk[j], outData[j]})),
                32'(routeExpect($sampled(routeSelWord[4*j +: 4]),
                    $sampled({ch0.symClk, ch0.symBit}), $sampled({ch1.symClk, ch1.symBit}))));
    end

    for (genvar i = 0; i < NumDacs; i++) begin : gDacCheck
        assert property (@(posedge clk) disable iff (reset) dacData[i] == dacExpect[i])
            else reportMismatch($sformatf("dacData[%0d]", i), 32'($sampled(dacData[i])),
                32'($sampled(dacExpect[i])));
    end

    // **************************************************************************
    // Bus and channel tasks
    // **************************************************************************
    task automatic writeReg(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] strobes);
        @(posedge clk);
        busIn.addr <= addr;
        busIn.data <= data;
        busIn.byteWr <= strobes;
        cs <= 1'b1;
        rd <= 1'b0;
        @(posedge clk);
        busIn.byteWr <= '0;
        cs <= 1'b0;
        if (addr[12:2] == bsBertPkg::DacSelectAddr[12:2]) begin
            dacSelWord <= mergeBytes(dacSelWord, data, strobes, 32'h0007_0707);
        end else if (addr[12:2] == bsBertPkg::RouteSelectAddr[12:2]) begin
            routeSelWord <= mergeBytes(routeSelWord, data, strobes, 32'h000f_ffff);
        end
    endtask

    task automatic readCheck(input logic [12:0] addr, input logic [15:0] expected);
        @(posedge clk);
        busIn.addr <= addr;
        busIn.byteWr <= '0;
        cs <= 1'b1;
        rd <= 1'b1;
        @(negedge clk);
        assert (readData == expected)
            else reportMismatch($sformatf("readData at 0x%h", addr), 32'(readData),
                32'(expected));
        @(posedge clk);
        cs <= 1'b0;
        rd <= 1'b0;
    endtask

    // Lower half-word first and then the upper
    task automatic readBoth(input logic [12:0] addr, input logic [31:0] expected);
        readCheck({addr[12:2], 2'b00}, expected[15:0]);
        readCheck({addr[12:2], 2'b10}, expected[31:16]);
    endtask

    task automatic sendSample(input logic toCh1, input bsBertPkg::sample_t value);
        @(posedge clk);
        if (toCh1) begin
            ch1.sample <= value;
            ch1.sampleEn <= 1'b1;
        end else begin
            ch0.sample <= value;
            ch0.sampleEn <= 1'b1;
        end
        @(posedge clk);
        ch0.sampleEn <= 1'b0;
        ch1.sampleEn <= 1'b0;
    endtask

    task automatic waitForDac(input int lane, input bsBertPkg::dacWord_t expected);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (dacData[lane] != expected) begin
            if (cycles == Timeout) begin
                $display("DAC lane %0d never reached 0x%h", lane, expected);
                stopOnFailure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic toggleSymbols(input int cycles);
        logic [5:0] bits;
        repeat (cycles) begin
            @(posedge clk);
            bits = 6'($random(seed));
            {ch0.symClk, ch0.symBit, ch0.lock, ch1.symClk, ch1.symBit, ch1.lock} <= bits;
        end
    endtask

    // **************************************************************************
    // Stimulus
    // **************************************************************************
    initial begin
        bsBertPkg::sample_t value;
        logic signed [31:0] extended;
        seed = 32'h37ba_cec8;
        reset <= 1'b1;
        ch0 <= '0;
        ch1 <= '0;
        busIn <= '0;
        cs <= 1'b0;
        rd <= 1'b0;
        dacSelWord <= '0;
        routeSelWord <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Reset state
        toggleSymbols(4);
        @(negedge clk);
        for (int i = 0; i < NumDacs; i++) begin
            assert (dacData[i] == bsBertPkg::DacMidscale)
                else reportMismatch("dacData after reset", 32'(dacData[i]), 32'h2000);
        end

        // Version word, byte strobes and read enable
        readBoth(bsBertPkg::VersionAddr, 32'(Version));
        writeReg(bsBertPkg::DacSelectAddr, 32'h0707_0707, 4'b0010);
        readBoth(bsBertPkg::DacSelectAddr, 32'h0000_0700);
        writeReg(bsBertPkg::RouteSelectAddr, 32'h0009_2402, 4'b1111);
        readBoth(bsBertPkg::RouteSelectAddr, 32'h0009_2402);
        toggleSymbols(6);
        writeReg(bsBertPkg::RouteSelectAddr, 32'h1234_5678, 4'b0100);
        readBoth(bsBertPkg::RouteSelectAddr, 32'h0004_2402);
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;

        // Each lane on channel 1 with a random sample
        for (int lane = 0; lane < NumDacs; lane++) begin
            writeReg(bsBertPkg::DacSelectAddr, 32'h0101_0101, 4'(1 << lane));
            value = 18'($random(seed));
            extended = value;
            sendSample(1'b1, value);
            waitForDac(lane, dacFromSample(value));
            readBoth(bsBertPkg::LaneReadBase + 13'(4 * lane), extended);
        end

        // Unused code on lane 2 falls back to channel 0
        writeReg(bsBertPkg::DacSelectAddr, 32'h0006_0000, 4'b0100);
        value = 18'($random(seed));
        sendSample(1'b0, value);
        waitForDac(2, dacFromSample(value));
        repeat (4) begin
            sendSample(1'b1, 18'($random(seed)));
        end
        @(negedge clk);
        assert (dacData[2] == dacFromSample(value))
            else reportMismatch("dacData[2] hold", 32'(dacData[2]), 32'(dacFromSample(value)));

        // Every router code on all five routers
        for (int code = 0; code < 16; code++) begin
            writeReg(bsBertPkg::RouteSelectAddr, {8{4'(code)}}, 4'b0111);
            toggleSymbols(6);
        end

        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/bsBertPkg.sv
logic/busRegs.sv
logic/dacLane.sv
logic/readbackMux.sv
logic/outputRouter.sv
logic/bsBertTop.sv
tests/tbClock.sv
tests/bsBertTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= bsBertTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
